//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and address width
`define CFG_XLEN 32

// Architectural registers, x0 included
`define CFG_NREGS 32

// PC value out of reset
`define CFG_START_ADDR 32'h0000_0000

// Store target that marks end of program
`define CFG_HALT_ADDR 32'h0000_0ffc

`endif

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes in bits [6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Register and immediate ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Load and store widths
    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SW      = 3'b010;

    // Branch conditions
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 of the register ALU group
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_cfg.svh"

package rv_pipe_pkg;

    // Register index sized from the bank depth
    typedef logic [$clog2(`CFG_NREGS)-1:0] reg_idx_t;

    // Operations carried down the pipe
    // OP_NOP marks an empty slot, illegal words decode to it too
    typedef enum logic [3:0] {
        OP_NOP,
        // ALU, ADDI shares OP_ADD
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        // Memory
        OP_LW,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SB,
        // Control flow
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

endpackage

//--- rv_pipe_if.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

// Decode to execute slot, no handshake
interface dec_exe_if
    import rv_pipe_pkg::*;
();
    op_e                  op;
    logic [`CFG_XLEN-1:0] rs1_data;
    logic [`CFG_XLEN-1:0] rs2_data;
    // Immediate or rs2, chosen in decode
    logic [`CFG_XLEN-1:0] operand2;
    reg_idx_t             rd;
    logic [`CFG_XLEN-1:0] pc;
    // Branch or JAL target, pc relative
    logic [`CFG_XLEN-1:0] jump_target;

    modport dec (output op, rs1_data, rs2_data, operand2, rd, pc, jump_target);
    modport exe (input  op, rs1_data, rs2_data, operand2, rd, pc, jump_target);
endinterface

// Execute to retire slot
interface exe_ret_if
    import rv_pipe_pkg::*;
();
    // Registered at the end of execute
    op_e                  op;
    reg_idx_t             rd;
    logic [`CFG_XLEN-1:0] result;
    logic                 we;
    logic [1:0]           offset;
    // Live execute result for the forward path into decode
    reg_idx_t             fwd_rd;
    logic [`CFG_XLEN-1:0] fwd_result;
    logic                 fwd_we;

    modport exe (output op, rd, result, we, offset, fwd_rd, fwd_result, fwd_we);
    modport ret (input  op, rd, result, we, offset);
    modport fwd (input  fwd_rd, fwd_result, fwd_we);
endinterface

//--- rv_fetch.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_fetch (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  logic                 hazard_i,
    input  logic                 jump_i,
    input  logic [`CFG_XLEN-1:0] jump_target_i,
    input  logic [`CFG_XLEN-1:0] instruction_i,
    output logic [`CFG_XLEN-1:0] instruction_address_o,
    output logic [`CFG_XLEN-1:0] instruction_o,
    output logic [`CFG_XLEN-1:0] pc_o,
    output logic                 valid_o
);

    // Next fetch address
    logic [`CFG_XLEN-1:0] pc;
    // Address of the word now arriving from memory
    logic [`CFG_XLEN-1:0] pc_fetched;
    logic                 fetched_valid;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc            <= `CFG_START_ADDR;
            pc_fetched    <= `CFG_START_ADDR;
            fetched_valid <= 1'b0;
        end else if (!stall_i) begin
            if (jump_i) begin
                // Word in flight belongs to the old path
                pc            <= jump_target_i;
                fetched_valid <= 1'b0;
            end else if (!hazard_i) begin
                pc            <= pc + `CFG_XLEN'(4);
                pc_fetched    <= pc;
                fetched_valid <= 1'b1;
            end
        end
    end

    // Load-use bubble re-reads the word held in decode
    assign instruction_address_o = hazard_i ? pc_fetched : pc;

    assign instruction_o = instruction_i;
    assign pc_o          = pc_fetched;
    assign valid_o       = fetched_valid;

endmodule

//--- rv_decode.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  logic [`CFG_XLEN-1:0] instruction_i,
    input  logic [`CFG_XLEN-1:0] pc_i,
    input  logic                 valid_i,
    input  logic                 jump_i,
    input  logic [`CFG_XLEN-1:0] rs1_data_i,
    input  logic [`CFG_XLEN-1:0] rs2_data_i,
    input  reg_idx_t             wb_rd_i,
    input  logic [`CFG_XLEN-1:0] wb_data_i,
    input  logic                 wb_we_i,
    output reg_idx_t             rs1_o,
    output reg_idx_t             rs2_o,
    output logic                 hazard_o,
    dec_exe_if.dec               de,
    exe_ret_if.fwd               fwd
);

////////////////////////////////////////////////////////////
// Fields and immediates
////////////////////////////////////////////////////////////

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CFG_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = opcode_e'(instruction_i[6:0]);
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign rs1_o  = instruction_i[19:15];
    assign rs2_o  = instruction_i[24:20];

    assign imm_i = {{(`CFG_XLEN-12){instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{(`CFG_XLEN-12){instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{(`CFG_XLEN-13){instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{(`CFG_XLEN-21){instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

////////////////////////////////////////////////////////////
// Operation
////////////////////////////////////////////////////////////

    op_e op_dec;

    always_comb begin
        op_dec = OP_NOP;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
                    op_dec = OP_SUB;
                end else if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD_SUB: op_dec = OP_ADD;
                        F3_SLT:     op_dec = OP_SLT;
                        F3_XOR:     op_dec = OP_XOR;
                        F3_OR:      op_dec = OP_OR;
                        F3_AND:     op_dec = OP_AND;
                        default:    op_dec = OP_NOP;
                    endcase
                end
            end
            // Only ADDI is kept from the immediate group
            OPC_OP_IMM: op_dec = (funct3 == F3_ADD_SUB) ? OP_ADD : OP_NOP;
            OPC_LUI:    op_dec = OP_LUI;
            OPC_LOAD: begin
                case (funct3)
                    F3_LW:   op_dec = OP_LW;
                    F3_LB:   op_dec = OP_LB;
                    F3_LBU:  op_dec = OP_LBU;
                    default: op_dec = OP_NOP;
                endcase
            end
            OPC_STORE: begin
                if (funct3 == F3_SW) op_dec = OP_SW;
                else if (funct3 == F3_SB) op_dec = OP_SB;
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) op_dec = OP_BEQ;
                else if (funct3 == F3_BNE) op_dec = OP_BNE;
            end
            OPC_JAL: op_dec = OP_JAL;
            default: op_dec = OP_NOP;
        endcase
    end

////////////////////////////////////////////////////////////
// Forwarding and load-use hazard
////////////////////////////////////////////////////////////

    logic [`CFG_XLEN-1:0] rs1_val, rs2_val, operand2;
    logic                 uses_rs1, uses_rs2;

    // Youngest producer wins, x0 always reads zero
    function automatic logic [`CFG_XLEN-1:0] pick_source(input reg_idx_t rs,
                                                        input logic [`CFG_XLEN-1:0] bank);
        if (rs == '0)
            return '0;
        if (fwd.fwd_we && fwd.fwd_rd == rs)
            return fwd.fwd_result;
        if (wb_we_i && wb_rd_i == rs)
            return wb_data_i;
        return bank;
    endfunction

    assign rs1_val = pick_source(rs1_o, rs1_data_i);
    assign rs2_val = pick_source(rs2_o, rs2_data_i);

    assign uses_rs1 = !(op_dec inside {OP_NOP, OP_LUI, OP_JAL});
    assign uses_rs2 = (op_dec != OP_NOP) && (opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH});

    // Load data only shows up in retire, so hold one cycle
    assign hazard_o = valid_i && (de.op inside {OP_LW, OP_LB, OP_LBU}) && (de.rd != '0)
                   && ((uses_rs1 && de.rd == rs1_o) || (uses_rs2 && de.rd == rs2_o));

    always_comb begin
        case (opcode)
            OPC_OP, OPC_BRANCH: operand2 = rs2_val;
            OPC_STORE:          operand2 = imm_s;
            OPC_LUI:            operand2 = imm_u;
            default:            operand2 = imm_i;
        endcase
    end

////////////////////////////////////////////////////////////
// Decode to execute register
////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de.op <= OP_NOP;
        end else if (!stall_i) begin
            // Flush on a taken jump, bubble on hazard
            de.op <= (jump_i || hazard_o || !valid_i) ? OP_NOP : op_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            de.rs1_data    <= rs1_val;
            de.rs2_data    <= rs2_val;
            de.operand2    <= operand2;
            de.rd          <= instruction_i[11:7];
            de.pc          <= pc_i;
            de.jump_target <= pc_i + ((opcode == OPC_JAL) ? imm_j : imm_b);
        end
    end

    // A load in execute is never a taken jump, so hold and redirect never meet
    a_hold_not_on_jump: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(hazard_o && jump_i));

endmodule

//--- rv_regbank.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regbank
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  reg_idx_t             rs1_i,
    input  reg_idx_t             rs2_i,
    input  reg_idx_t             rd_i,
    input  logic                 we_i,
    input  logic [`CFG_XLEN-1:0] data_i,
    output logic [`CFG_XLEN-1:0] data1_o,
    output logic [`CFG_XLEN-1:0] data2_o
);

    // x0 has no storage
    logic [`CFG_XLEN-1:0] regs [1:`CFG_NREGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `CFG_NREGS; i++)
                regs[i] <= '0;
        end else if (we_i && !stall_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Asynchronous read ports
    assign data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_execute
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    output logic                 jump_o,
    output logic [`CFG_XLEN-1:0] jump_target_o,
    output logic [`CFG_XLEN-1:0] mem_address_o,
    output logic                 mem_read_o,
    output logic [3:0]           mem_write_enable_o,
    output logic [`CFG_XLEN-1:0] mem_data_o,
    dec_exe_if.exe               de,
    exe_ret_if.exe               er
);

    logic [`CFG_XLEN-1:0] sum;
    logic [`CFG_XLEN-1:0] result;
    logic                 equal;
    logic                 is_load;
    logic                 writes_rd;

////////////////////////////////////////////////////////////
// ALU and branch compare
////////////////////////////////////////////////////////////

    // Shared by ADD, ADDI and address generation
    assign sum   = de.rs1_data + de.operand2;
    assign equal = (de.rs1_data == de.rs2_data);

    always_comb begin
        case (de.op)
            OP_ADD:  result = sum;
            OP_SUB:  result = de.rs1_data - de.operand2;
            OP_AND:  result = de.rs1_data & de.operand2;
            OP_OR:   result = de.rs1_data | de.operand2;
            OP_XOR:  result = de.rs1_data ^ de.operand2;
            OP_SLT:  result = {{(`CFG_XLEN-1){1'b0}},
                               $signed(de.rs1_data) < $signed(de.operand2)};
            OP_LUI:  result = de.operand2;
            // Link value
            OP_JAL:  result = de.pc + `CFG_XLEN'(4);
            default: result = sum;
        endcase
    end

    assign is_load   = de.op inside {OP_LW, OP_LB, OP_LBU};
    assign writes_rd = de.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_LUI,
                                     OP_LW, OP_LB, OP_LBU, OP_JAL};

    assign jump_o = (de.op == OP_JAL) || (de.op == OP_BEQ && equal)
                 || (de.op == OP_BNE && !equal);
    assign jump_target_o = de.jump_target;

////////////////////////////////////////////////////////////
// Data memory request
////////////////////////////////////////////////////////////

    assign mem_address_o = {sum[`CFG_XLEN-1:2], 2'b00};
    assign mem_read_o    = is_load;

    always_comb begin
        case (de.op)
            OP_SW:   mem_write_enable_o = 4'b1111;
            OP_SB:   mem_write_enable_o = 4'b0001 << sum[1:0];
            default: mem_write_enable_o = 4'b0000;
        endcase
    end

    // Byte replicated on all lanes, enables pick one
    assign mem_data_o = (de.op == OP_SB) ? {4{de.rs2_data[7:0]}} : de.rs2_data;

////////////////////////////////////////////////////////////
// Forward path and execute to retire register
////////////////////////////////////////////////////////////

    // Loads are not ready here, decode stalls on them
    assign er.fwd_rd     = de.rd;
    assign er.fwd_result = result;
    assign er.fwd_we     = writes_rd && !is_load;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            er.op <= OP_NOP;
            er.we <= 1'b0;
        end else if (!stall_i) begin
            er.op <= de.op;
            er.we <= writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            er.rd     <= de.rd;
            er.result <= result;
            er.offset <= sum[1:0];
        end
    end

    // Stalled request stays on the data port until it is accepted
    a_stall_holds_request: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable({mem_read_o, mem_write_enable_o, mem_address_o, mem_data_o}));

endmodule

//--- rv_retire.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_retire
    import rv_pipe_pkg::*;
(
    input  logic [`CFG_XLEN-1:0] mem_data_i,
    exe_ret_if.ret               er,
    output reg_idx_t             wb_rd_o,
    output logic [`CFG_XLEN-1:0] wb_data_o,
    output logic                 wb_we_o
);

    logic [7:0] load_byte;

    // Lane from the low address bits
    always_comb begin
        case (er.offset)
            2'd0:    load_byte = mem_data_i[7:0];
            2'd1:    load_byte = mem_data_i[15:8];
            2'd2:    load_byte = mem_data_i[23:16];
            default: load_byte = mem_data_i[31:24];
        endcase
    end

    always_comb begin
        case (er.op)
            OP_LW:   wb_data_o = mem_data_i;
            OP_LB:   wb_data_o = {{(`CFG_XLEN-8){load_byte[7]}}, load_byte};
            OP_LBU:  wb_data_o = {{(`CFG_XLEN-8){1'b0}}, load_byte};
            // ALU result or link
            default: wb_data_o = er.result;
        endcase
    end

    assign wb_rd_o = er.rd;
    // x0 never written
    assign wb_we_o = er.we && (er.rd != '0);

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core
    import rv_pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 stall_i,
    input  logic [`CFG_XLEN-1:0] instruction_i,
    input  logic [`CFG_XLEN-1:0] mem_data_i,
    output logic [`CFG_XLEN-1:0] instruction_address_o,
    output logic                 mem_operation_enable_o,
    output logic [3:0]           mem_write_enable_o,
    output logic [`CFG_XLEN-1:0] mem_address_o,
    output logic [`CFG_XLEN-1:0] mem_data_o
);

////////////////////////////////////////////////////////////
// Pipeline signals
////////////////////////////////////////////////////////////

    logic                 jump;
    logic [`CFG_XLEN-1:0] jump_target;
    logic                 hazard;

    // Fetch to decode
    logic [`CFG_XLEN-1:0] instruction_decode;
    logic [`CFG_XLEN-1:0] pc_decode;
    logic                 valid_decode;

    // Register bank ports
    reg_idx_t             rs1, rs2;
    logic [`CFG_XLEN-1:0] regbank_data1, regbank_data2;
    reg_idx_t             wb_rd;
    logic [`CFG_XLEN-1:0] wb_data;
    logic                 wb_we;

    logic                 mem_read;

    dec_exe_if de_if ();
    exe_ret_if er_if ();

////////////////////////////////////////////////////////////
// Stages
////////////////////////////////////////////////////////////

    rv_fetch fetch_inst (
        .clk                  (clk),
        .arst_n_i             (arst_n_i),
        .stall_i              (stall_i),
        .hazard_i             (hazard),
        .jump_i               (jump),
        .jump_target_i        (jump_target),
        .instruction_i        (instruction_i),
        .instruction_address_o(instruction_address_o),
        .instruction_o        (instruction_decode),
        .pc_o                 (pc_decode),
        .valid_o              (valid_decode)
    );

    rv_decode decode_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_i),
        .instruction_i(instruction_decode),
        .pc_i         (pc_decode),
        .valid_i      (valid_decode),
        .jump_i       (jump),
        .rs1_data_i   (regbank_data1),
        .rs2_data_i   (regbank_data2),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .wb_we_i      (wb_we),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .hazard_o     (hazard),
        .de           (de_if.dec),
        .fwd          (er_if.fwd)
    );

    rv_regbank regbank_inst (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .stall_i (stall_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (wb_rd),
        .we_i    (wb_we),
        .data_i  (wb_data),
        .data1_o (regbank_data1),
        .data2_o (regbank_data2)
    );

    rv_execute execute_inst (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .stall_i           (stall_i),
        .jump_o            (jump),
        .jump_target_o     (jump_target),
        .mem_address_o     (mem_address_o),
        .mem_read_o        (mem_read),
        .mem_write_enable_o(mem_write_enable_o),
        .mem_data_o        (mem_data_o),
        .de                (de_if.exe),
        .er                (er_if.exe)
    );

    rv_retire retire_inst (
        .mem_data_i(mem_data_i),
        .er        (er_if.ret),
        .wb_rd_o   (wb_rd),
        .wb_data_o (wb_data),
        .wb_we_o   (wb_we)
    );

    // Any read or write lane counts as a request
    assign mem_operation_enable_o = mem_read || (mem_write_enable_o != 4'b0000);

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;

    localparam int STIM_WORDS = 512;
    // Layout of the stim image
    localparam int REC_BASE   = 'h100;
    localparam int COUNT_IDX  = 'h1ff;
    localparam int PROG_MAX   = 256;

    logic                 clk;
    logic                 arst_n_i;
    logic                 stall_i;
    logic [`CFG_XLEN-1:0] instruction_i;
    logic [`CFG_XLEN-1:0] mem_data_i;
    logic [`CFG_XLEN-1:0] instruction_address_o;
    logic                 mem_operation_enable_o;
    logic [3:0]           mem_write_enable_o;
    logic [`CFG_XLEN-1:0] mem_address_o;
    logic [`CFG_XLEN-1:0] mem_data_o;

    // Program, expected stores and count, all from one file
    logic [31:0] stim [0:STIM_WORDS-1];
    // Data memory, 4 KiB
    logic [31:0] dmem [0:1023];

    int     seed = 88;
    int     errors = 0;
    int     prog_words = 0;
    int     rec_count = 0;
    int     rec_idx = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    bit     seen_store = 0;
    bit     halted = 0;
    bit     timed_out = 0;

    rv_core rv_core_inst (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .mem_data_i            (mem_data_i),
        .instruction_address_o (instruction_address_o),
        .mem_operation_enable_o(mem_operation_enable_o),
        .mem_write_enable_o    (mem_write_enable_o),
        .mem_address_o         (mem_address_o),
        .mem_data_o            (mem_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Closing line, then verdict
    task automatic end_run();
        $display("Run finished: %0d errors, %0d of %0d stores checked",
                 errors, rec_idx, rec_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

////////////////////////////////////////////////////////////
// Setup and reset
////////////////////////////////////////////////////////////

    initial begin
        arst_n_i      = 1'b0;
        stall_i       = 1'b0;
        instruction_i = '0;
        mem_data_i    = '0;
        for (int i = 0; i < STIM_WORDS; i++)
            stim[i] = '0;
        $readmemh("rv_stim.txt", stim);
        // Program ends at the first all-zero word
        while (prog_words < PROG_MAX && stim[prog_words] != '0)
            prog_words++;
        rec_count   = stim[COUNT_IDX];
        cycle_limit = 40 * prog_words;
        // Fill pattern from the whole word index
        for (int i = 0; i < 1024; i++)
            dmem[i] = {~i[9:0], 6'h2a, i[9:0], 6'h15};
        // Constants the program loads
        dmem['h100 >> 2] = 32'h80ff_7f85;
        dmem['h104 >> 2] = 32'h1122_3344;
        repeat (3) @(posedge clk);
        #2 arst_n_i = 1'b1;
        #1;
        assert (instruction_address_o == `CFG_START_ADDR) else begin
            errors++;
            $display("[ERROR] %0t: first fetch address %h, expected %h",
                     $time, instruction_address_o, `CFG_START_ADDR);
        end
        assert (!mem_operation_enable_o && mem_write_enable_o == 4'b0000) else begin
            errors++;
            $display("[ERROR] %0t: memory request active right after reset", $time);
        end
    end

    // End of run on the halt store or the cycle limit
    initial begin
        wait (halted || timed_out);
        if (!halted) begin
            errors++;
            $display("Timeout: program did not reach the halt store in %0d cycles",
                     cycle_limit);
        end
        end_run();
    end

////////////////////////////////////////////////////////////
// Memory models and store checks
////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [31:0] next_instr;
        logic [31:0] next_rdata;
        logic [31:0] exp_addr, exp_data, exp_be;
        logic [9:0]  widx;
        if (arst_n_i) begin
            next_instr = instruction_i;
            next_rdata = mem_data_i;
            widx       = mem_address_o[11:2];
            cycles++;
            if (!stall_i) begin
                // Synchronous instruction read
                next_instr = stim[instruction_address_o[10:2]];
                if (!seen_store) begin
                    assert (!mem_operation_enable_o || mem_write_enable_o != 4'b0000)
                    else begin
                        errors++;
                        $display("[ERROR] %0t: memory read before the first store", $time);
                    end
                end
                if (mem_write_enable_o != 4'b0000) begin
                    seen_store = 1'b1;
                    if (mem_address_o == `CFG_HALT_ADDR) begin
                        assert (rec_idx == rec_count) else begin
                            errors++;
                            $display("Halt store reached with %0d of %0d stores seen",
                                     rec_idx, rec_count);
                        end
                        halted = 1'b1;
                    end else if (rec_idx >= rec_count) begin
                        errors++;
                        $display("[ERROR] %0t: extra store to %h data %h",
                                 $time, mem_address_o, mem_data_o);
                    end else begin
                        exp_addr = stim[REC_BASE + 3 * rec_idx];
                        exp_data = stim[REC_BASE + 3 * rec_idx + 1];
                        exp_be   = stim[REC_BASE + 3 * rec_idx + 2];
                        assert (mem_address_o == exp_addr && mem_data_o == exp_data
                                && mem_write_enable_o == exp_be[3:0]) else begin
                            errors++;
                            $display("[ERROR] %0t: store %0d expected %h/%h/%h got %h/%h/%h",
                                     $time, rec_idx, exp_addr, exp_data, exp_be[3:0],
                                     mem_address_o, mem_data_o, mem_write_enable_o);
                        end
                        rec_idx++;
                    end
                    // Byte lane writes
                    for (int b = 0; b < 4; b++)
                        if (mem_write_enable_o[b])
                            dmem[widx][8*b +: 8] = mem_data_o[8*b +: 8];
                end else if (mem_operation_enable_o) begin
                    next_rdata = dmem[widx];
                end
            end
            if (cycles >= cycle_limit)
                timed_out = 1'b1;
            #2;
            instruction_i = next_instr;
            mem_data_i    = next_rdata;
            // Random stall only once the first store has passed
            if (seen_store)
                stall_i = (($random(seed) & 3) == 0);
            else
                stall_i = 1'b0;
        end
    end

endmodule

//--- rv_stim.txt
// Program words at @000, four per line, in address order
// Store records at @100: address data byte-enable; record count at @1ff
@000
06400093 ff900113 002081b3 40208233
0020f2b3 0020e333 0020c3b3 00112433
0020a4b3 abcde537 12350513 20302023
20402223 20502423 20602623 20702823
20802a23 20902c23 20a02e23 10002583
00158613 22c02023 10000683 10304703
10100783 22d02223 22e02423 22f02623
101002a3 10402803 23002823 00208463
22102a23 00209663 2e102823 2e102823
00108663 2e102823 2e102823 00109463
00c008ef 2e102823 2e102823 23102c23
00001937 fe192e23 0000006f
@100
00000200 0000005d 0000000f
00000204 0000006b 0000000f
00000208 00000060 0000000f
0000020c fffffffd 0000000f
00000210 ffffff9d 0000000f
00000214 00000001 0000000f
00000218 00000000 0000000f
0000021c abcde123 0000000f
00000220 80ff7f86 0000000f
00000224 ffffff85 0000000f
00000228 00000080 0000000f
0000022c 0000007f 0000000f
00000104 64646464 00000002
00000230 11226444 0000000f
00000234 00000064 0000000f
00000238 000000a4 0000000f
@1ff
00000010

//--- build.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_pipe_if.sv
rv_fetch.sv
rv_decode.sv
rv_regbank.sv
rv_execute.sv
rv_retire.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_rv_core -o Vtb_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
